//--- source/i2c_pkg.sv
package i2c_pkg;

	// bit timing in clk cycles.
	localparam int bit_cycles = 20;
	localparam int scl_rise_cnt = 5; // one quarter of the bit.
	localparam int scl_fall_cnt = 15; // three quarters of the bit.
	localparam int sda_change_cnt = 0; // scl is low here.
	localparam int sda_sample_cnt = 10; // middle of the high phase.
	localparam int cnt_w = 5;

	// command payload.
	localparam int dev_w = 7;
	localparam int byte_w = 8;
	localparam int bit_idx_w = 3;

	// command queue.
	localparam int fifo_depth = 4;
	localparam int ptr_w = $clog2(fifo_depth);
	localparam int occ_w = $clog2(fifo_depth + 1);

	// write transaction sequence with one state per bus phase.
	typedef enum logic [3:0] {
		idle = 4'd0,
		start = 4'd1,
		dev_byte = 4'd2,
		dev_ack = 4'd3,
		reg_byte = 4'd4,
		reg_ack = 4'd5,
		data_byte = 4'd6,
		data_ack = 4'd7,
		stop = 4'd8
	} master_state_t;

endpackage

//--- source/i2c_cmd_fifo.sv
`timescale 1ns/1ps

module i2c_cmd_fifo (
	input  logic                       clk,
	input  logic                       rst_n,
	input  logic                       wr,
	input  logic [i2c_pkg::dev_w-1:0]  wr_dev,
	input  logic [i2c_pkg::byte_w-1:0] wr_reg,
	input  logic [i2c_pkg::byte_w-1:0] wr_data,
	input  logic                       pop,
	output logic                       fifo_empty,
	output logic [i2c_pkg::dev_w-1:0]  fifo_dev,
	output logic [i2c_pkg::byte_w-1:0] fifo_reg,
	output logic [i2c_pkg::byte_w-1:0] fifo_data,
	output logic                       overflow
);
	import i2c_pkg::*;

	logic [dev_w-1:0]  mem_dev  [fifo_depth];
	logic [byte_w-1:0] mem_reg  [fifo_depth];
	logic [byte_w-1:0] mem_data [fifo_depth];

	logic [ptr_w-1:0] wr_ptr;
	logic [ptr_w-1:0] rd_ptr;
	logic [occ_w-1:0] count;
	logic full;
	logic wr_ok;
	logic pop_ok;

	assign full = (count == occ_w'(fifo_depth));
	assign fifo_empty = (count == '0);
	assign pop_ok = pop && !fifo_empty;
	assign wr_ok = wr && (!full || pop_ok); // a pop frees the slot in the same cycle.

	assign fifo_dev = mem_dev[rd_ptr];
	assign fifo_reg = mem_reg[rd_ptr];
	assign fifo_data = mem_data[rd_ptr];

	always_ff @(posedge clk) begin
		if (wr_ok) begin
			mem_dev[wr_ptr] <= wr_dev;
			mem_reg[wr_ptr] <= wr_reg;
			mem_data[wr_ptr] <= wr_data;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			overflow <= 1'b0;
		end else begin
			if (wr_ok) begin
				wr_ptr <= (wr_ptr == ptr_w'(fifo_depth - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (pop_ok) begin
				rd_ptr <= (rd_ptr == ptr_w'(fifo_depth - 1)) ? '0 : rd_ptr + 1'b1;
			end
			case ({wr_ok, pop_ok})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
			overflow <= wr && !wr_ok; // dropped command.
		end
	end

endmodule

//--- source/i2c_bit_timer.sv
`timescale 1ns/1ps

module i2c_bit_timer (
	input  logic clk,
	input  logic rst_n,
	input  logic run,
	input  logic bit_restart,
	input  logic hold_scl_high,
	output logic scl,
	output logic bit_end,
	output logic sda_tick,
	output logic sample_tick
);
	import i2c_pkg::*;

	logic [cnt_w-1:0] cnt;
	logic at_last;
	logic at_rise;
	logic at_fall;

	assign at_last = (cnt == cnt_w'(bit_cycles - 1));
	assign at_rise = (cnt == cnt_w'(scl_rise_cnt));
	assign at_fall = (cnt == cnt_w'(scl_fall_cnt));

	// phase strobes only while a transfer runs.
	assign bit_end = run && at_last;
	assign sda_tick = run && (cnt == cnt_w'(sda_change_cnt));
	assign sample_tick = run && (cnt == cnt_w'(sda_sample_cnt));

	// held at zero while idle, so the first bit after run rises starts at count 0.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cnt <= '0;
		end else if (!run || bit_restart || at_last) begin
			cnt <= '0;
		end else begin
			cnt <= cnt + 1'b1;
		end
	end

	// scl high at one quarter and low at three quarters of each bit.
	// the fall on the last count only matters for the start bit, where scl
	// has been held high; every other bit is already low by then.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			scl <= 1'b1;
		end else if (!run) begin
			scl <= 1'b1; // bus idle.
		end else if (hold_scl_high) begin
			scl <= 1'b1;
		end else if (at_rise) begin
			scl <= 1'b1;
		end else if (at_fall || at_last) begin
			scl <= 1'b0;
		end
	end

endmodule

//--- source/i2c_write_master.sv
`timescale 1ns/1ps

module i2c_write_master (
	input  logic                       clk,
	input  logic                       rst_n,
	input  logic                       fifo_empty,
	input  logic [i2c_pkg::dev_w-1:0]  fifo_dev,
	input  logic [i2c_pkg::byte_w-1:0] fifo_reg,
	input  logic [i2c_pkg::byte_w-1:0] fifo_data,
	input  logic                       sda_in,
	input  logic                       bit_end,
	input  logic                       sda_tick,
	input  logic                       sample_tick,
	output logic                       pop,
	output logic                       run,
	output logic                       bit_restart,
	output logic                       hold_scl_high,
	output logic                       sda_drive_low,
	output logic                       done,
	output logic                       nack,
	output logic                       busy
);
	import i2c_pkg::*;

	master_state_t state;
	master_state_t next_state;

	logic [byte_w-1:0] shift_q;
	logic [byte_w-1:0] reg_q;
	logic [byte_w-1:0] data_q;
	logic [bit_idx_w-1:0] bit_cnt;
	logic nack_q;
	logic stop_rel;
	logic in_byte;
	logic in_ack;
	logic last_bit;
	logic take_cmd;

	assign in_byte = (state == dev_byte) || (state == reg_byte) || (state == data_byte);
	assign in_ack = (state == dev_ack) || (state == reg_ack) || (state == data_ack);
	assign last_bit = bit_end && (bit_cnt == bit_idx_w'(byte_w - 1));
	assign take_cmd = (state == idle) && (next_state == start);

	assign run = (state != idle);
	assign busy = (state != idle);
	assign bit_restart = (next_state != state);
	// released in the last cycle of start so scl falls before the first data bit.
	assign hold_scl_high = ((state == start) && !bit_end) || stop_rel;

	always_comb begin
		next_state = state;
		case (state)
			idle: begin
				if (!fifo_empty) begin
					next_state = start;
				end
			end
			start: begin
				if (bit_end) begin
					next_state = dev_byte;
				end
			end
			dev_byte: begin
				if (last_bit) begin
					next_state = dev_ack;
				end
			end
			dev_ack: begin
				if (bit_end) begin
					next_state = nack_q ? stop : reg_byte;
				end
			end
			reg_byte: begin
				if (last_bit) begin
					next_state = reg_ack;
				end
			end
			reg_ack: begin
				if (bit_end) begin
					next_state = nack_q ? stop : data_byte;
				end
			end
			data_byte: begin
				if (last_bit) begin
					next_state = data_ack;
				end
			end
			data_ack: begin
				if (bit_end) begin
					next_state = stop;
				end
			end
			stop: begin
				if (bit_end) begin
					next_state = idle;
				end
			end
			default: next_state = idle;
		endcase
	end

	// command bytes leave msb first through shift_q.
	always_ff @(posedge clk) begin
		if (take_cmd) begin
			shift_q <= {fifo_dev, 1'b0}; // write bit.
			reg_q <= fifo_reg;
			data_q <= fifo_data;
		end else if ((state == dev_ack) && (next_state == reg_byte)) begin
			shift_q <= reg_q;
		end else if ((state == reg_ack) && (next_state == data_byte)) begin
			shift_q <= data_q;
		end else if (in_byte && bit_end) begin
			shift_q <= {shift_q[byte_w-2:0], 1'b0};
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= idle;
			pop <= 1'b0;
			done <= 1'b0;
			nack <= 1'b0;
			nack_q <= 1'b0;
			stop_rel <= 1'b0;
			bit_cnt <= '0;
		end else begin
			state <= next_state;
			pop <= take_cmd; // head entry already latched.
			done <= (state == stop) && (next_state == idle);
			if ((state == stop) && (next_state == idle)) begin
				nack <= nack_q;
			end

			if (take_cmd) begin
				nack_q <= 1'b0;
			end else if (in_ack && sample_tick && sda_in) begin
				nack_q <= 1'b1; // no ack from the target.
			end

			if (state != stop) begin
				stop_rel <= 1'b0;
			end else if (sample_tick) begin
				stop_rel <= 1'b1;
			end

			if (bit_restart) begin
				bit_cnt <= '0;
			end else if (in_byte && bit_end) begin
				bit_cnt <= bit_cnt + 1'b1;
			end
		end
	end

	// sda moves only at sda_tick while scl is low, except at start and stop.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			sda_drive_low <= 1'b0;
		end else if (take_cmd) begin
			sda_drive_low <= 1'b1; // start condition.
		end else if (in_byte && sda_tick) begin
			sda_drive_low <= !shift_q[byte_w-1];
		end else if (in_ack && sda_tick) begin
			sda_drive_low <= 1'b0;
		end else if ((state == stop) && sda_tick) begin
			sda_drive_low <= 1'b1;
		end else if ((state == stop) && sample_tick) begin
			sda_drive_low <= 1'b0; // stop condition.
		end else if (state == idle) begin
			sda_drive_low <= 1'b0;
		end
	end

endmodule

//--- source/i2c_write_top.sv
`timescale 1ns/1ps

module i2c_write_top (
	input  logic                       clk,
	input  logic                       rst_n,
	input  logic                       cmd_valid,
	input  logic [i2c_pkg::dev_w-1:0]  cmd_dev,
	input  logic [i2c_pkg::byte_w-1:0] cmd_reg,
	input  logic [i2c_pkg::byte_w-1:0] cmd_data,
	output logic                       cmd_overflow,
	output logic                       done,
	output logic                       nack,
	output logic                       busy,
	output logic                       scl,
	inout  wire                        sda
);
	import i2c_pkg::*;

	logic fifo_empty;
	logic [dev_w-1:0] fifo_dev;
	logic [byte_w-1:0] fifo_reg;
	logic [byte_w-1:0] fifo_data;
	logic pop;
	logic run;
	logic bit_restart;
	logic hold_scl_high;
	logic bit_end;
	logic sda_tick;
	logic sample_tick;
	logic sda_drive_low;
	logic sda_in;

	// open drain with an external pull-up.
	assign sda = sda_drive_low ? 1'b0 : 1'bz;
	assign sda_in = sda;

	i2c_cmd_fifo i_fifo (
		.clk        (clk),
		.rst_n      (rst_n),
		.wr         (cmd_valid),
		.wr_dev     (cmd_dev),
		.wr_reg     (cmd_reg),
		.wr_data    (cmd_data),
		.pop        (pop),
		.fifo_empty (fifo_empty),
		.fifo_dev   (fifo_dev),
		.fifo_reg   (fifo_reg),
		.fifo_data  (fifo_data),
		.overflow   (cmd_overflow)
	);

	i2c_write_master i_master (
		.clk           (clk),
		.rst_n         (rst_n),
		.fifo_empty    (fifo_empty),
		.fifo_dev      (fifo_dev),
		.fifo_reg      (fifo_reg),
		.fifo_data     (fifo_data),
		.sda_in        (sda_in),
		.bit_end       (bit_end),
		.sda_tick      (sda_tick),
		.sample_tick   (sample_tick),
		.pop           (pop),
		.run           (run),
		.bit_restart   (bit_restart),
		.hold_scl_high (hold_scl_high),
		.sda_drive_low (sda_drive_low),
		.done          (done),
		.nack          (nack),
		.busy          (busy)
	);

	i2c_bit_timer i_timer (
		.clk           (clk),
		.rst_n         (rst_n),
		.run           (run),
		.bit_restart   (bit_restart),
		.hold_scl_high (hold_scl_high),
		.scl           (scl),
		.bit_end       (bit_end),
		.sda_tick      (sda_tick),
		.sample_tick   (sample_tick)
	);

endmodule

//--- dv/i2c_slave_model.sv
`timescale 1ns/1ps

module i2c_slave_model #(
	parameter logic [6:0] own_addr = 7'h50
) (
	input  logic       scl,
	inout  wire        sda,
	output logic [7:0] frame_dev,
	output logic [7:0] frame_reg,
	output logic [7:0] frame_data,
	output int         frame_bytes,
	output int         frame_cnt
);
	logic sda_low = 1'b0;
	logic in_frame = 1'b0;
	logic ack_slot = 1'b0;
	logic matched = 1'b0;
	logic [7:0] shreg;
	logic [7:0] rx [3];
	int bit_cnt;
	int byte_cnt;

	assign sda = sda_low ? 1'b0 : 1'bz;

	initial frame_cnt = 0;

	// start and stop are the only sda edges while scl is high.
	always @(sda) begin
		if (scl === 1'b1 && sda === 1'b0) begin
			in_frame = 1'b1;
			ack_slot = 1'b0;
			matched = 1'b0;
			bit_cnt = 0;
			byte_cnt = 0;
		end else if (scl === 1'b1 && in_frame) begin
			in_frame = 1'b0; // frame published at stop.
			frame_dev = rx[0];
			frame_reg = rx[1];
			frame_data = rx[2];
			frame_bytes = byte_cnt;
			frame_cnt = frame_cnt + 1;
		end
	end

	always @(posedge scl) begin
		if (in_frame && !ack_slot) begin
			shreg = {shreg[6:0], sda}; // msb first.
			bit_cnt++;
		end
	end

	// ack held low from the fall after bit 8 to the fall that ends the ack slot.
	always @(negedge scl) begin
		if (in_frame && ack_slot) begin
			ack_slot = 1'b0;
			sda_low = 1'b0;
		end else if (in_frame && bit_cnt == 8) begin
			if (byte_cnt == 0) begin
				matched = (shreg == {own_addr, 1'b0}); // write to this target only.
			end
			if (byte_cnt < 3) begin
				rx[byte_cnt] = shreg;
			end
			byte_cnt++;
			bit_cnt = 0;
			ack_slot = 1'b1;
			sda_low = matched;
		end
	end

endmodule

//--- dv/i2c_write_chk.sv
`timescale 1ns/1ps

module i2c_write_chk (
	input logic clk,
	input logic rst_n,
	input logic done,
	input logic cmd_overflow,
	input logic busy,
	input logic scl,
	input logic sda
);
	import i2c_pkg::*;

	int fails = 0;

	a_done_pulse: assert property (@(posedge clk) disable iff (!rst_n) done |=> !done)
		else begin
			$error("done stayed high for more than one cycle");
			fails++;
		end

	a_ovf_pulse: assert property (@(posedge clk) disable iff (!rst_n)
		cmd_overflow |=> !cmd_overflow)
		else begin
			$error("cmd_overflow stayed high for more than one cycle");
			fails++;
		end

	// under a high scl sda falls only as a start, when busy rises.
	a_sda_start: assert property (@(posedge clk) disable iff (!rst_n)
		(scl && $past(scl) && $fell(sda)) |-> $rose(busy))
		else begin
			$error("sda fell while scl was high other than at a start");
			fails++;
		end

	// a stop rise leaves scl high, a data bit would see scl fall first.
	a_sda_stop: assert property (@(posedge clk) disable iff (!rst_n)
		(scl && $past(scl) && $rose(sda)) |-> busy ##(bit_cycles / 2) scl)
		else begin
			$error("sda rose while scl was high other than at a stop");
			fails++;
		end

	a_scl_idle: assert property (@(posedge clk) disable iff (!rst_n) !busy |-> scl)
		else begin
			$error("scl low while the master is idle");
			fails++;
		end

endmodule

bind i2c_write_top i2c_write_chk i_chk (
	.clk          (clk),
	.rst_n        (rst_n),
	.done         (done),
	.cmd_overflow (cmd_overflow),
	.busy         (busy),
	.scl          (scl),
	.sda          (sda)
);

//--- dv/i2c_write_tb.sv
`timescale 1ns/1ps

module i2c_write_tb;
	import i2c_pkg::*;

	localparam logic [dev_w-1:0] slave_addr = 7'h50;
	localparam int wait_limit = 8000; // about a dozen full transfers.

	logic clk = 1'b0;
	logic rst_n;
	logic cmd_valid;
	logic [dev_w-1:0] cmd_dev;
	logic [byte_w-1:0] cmd_reg;
	logic [byte_w-1:0] cmd_data;
	logic cmd_overflow;
	logic done;
	logic nack;
	logic busy;
	logic scl;
	wire sda;
	logic [7:0] frame_dev;
	logic [7:0] frame_reg;
	logic [7:0] frame_data;
	int frame_bytes;
	int frame_cnt;

	logic [dev_w+2*byte_w-1:0] exp_q [$]; // queued or in flight as {dev, reg, data}.
	int seed;
	int errors;
	int timeouts;
	int dones;
	int busy_cycles;
	int scl_falls;
	int ovf_seen;
	logic scl_prev = 1'b1;
	logic busy_prev = 1'b0;
	logic ovf_pending = 1'b0; // drop expected on the next cycle.

	pullup (sda);

	always #10 clk = ~clk;

	i2c_write_top i_dut (.*);
	i2c_slave_model #(.own_addr(slave_addr)) i_slave (.*);

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected) begin
			errors++;
			$display("[ERROR] %0t ns %s expected %0h actual %0h", $time, name, expected, actual);
		end
	endtask

	function automatic logic [dev_w-1:0] pick_dev();
		logic [dev_w-1:0] dev;
		dev = dev_w'($random(seed));
		if (dev == slave_addr || ($random(seed) & 3) != 0) begin
			dev = slave_addr; // three in four go to the target.
		end
		return dev;
	endfunction

	// one clock, then the reference model follows the outputs.
	task automatic step_cycle();
		logic [dev_w+2*byte_w-1:0] head;
		logic acked;
		@(posedge clk);
		#1;
		check_value("cmd_overflow", ovf_pending, cmd_overflow);
		ovf_pending = 1'b0;
		ovf_seen += cmd_overflow;
		if (busy && !busy_prev) begin
			busy_cycles = 0;
			scl_falls = 0;
		end
		busy_cycles += busy;
		scl_falls += (scl_prev && !scl);
		scl_prev = scl;
		busy_prev = busy;
		if (done) begin
			check_value("{busy,scl,sda}", 3'b011, {busy, scl, sda});
			if (exp_q.size() == 0) begin
				errors++;
				$display("done pulsed at %0t ns with no command outstanding", $time);
			end else begin
				head = exp_q.pop_front();
				acked = (head[22:16] == slave_addr);
				dones++;
				check_value("nack", !acked, nack);
				check_value("frame_cnt", dones, frame_cnt);
				check_value("frame_dev", {head[22:16], 1'b0}, frame_dev);
				check_value("frame_bytes", acked ? 3 : 1, frame_bytes);
				if (acked) begin
					check_value("frame_reg", head[15:8], frame_reg);
					check_value("frame_data", head[7:0], frame_data);
					check_value("scl_falls", 28, scl_falls);
					check_value("busy_cycles", 29 * bit_cycles, busy_cycles);
				end
			end
		end
	endtask

	task automatic issue_cmd(input logic [dev_w-1:0] dev);
		cmd_valid = 1'b1;
		cmd_dev = dev;
		cmd_reg = byte_w'($random(seed));
		cmd_data = byte_w'($random(seed));
		// the command in flight has already left the queue.
		if (exp_q.size() - int'(busy) >= fifo_depth) begin
			ovf_pending = 1'b1;
		end else begin
			exp_q.push_back({dev, cmd_reg, cmd_data});
		end
		step_cycle();
		cmd_valid = 1'b0;
		step_cycle();
	endtask

	task automatic wait_idle();
		int n;
		n = 0;
		while ((exp_q.size() != 0 || busy) && n < wait_limit) begin
			step_cycle();
			n++;
		end
		if (exp_q.size() != 0 || busy) begin
			timeouts++;
			$display("transfers still outstanding after %0d cycles", wait_limit);
		end
	endtask

	initial begin
		seed = 22;
		rst_n = 1'b0;
		{cmd_valid, cmd_dev, cmd_reg, cmd_data} = '0;
		repeat (4) @(posedge clk);
		#1;
		rst_n = 1'b1;
		step_cycle();
		check_value("{scl,sda,busy,done}", 4'b1100, {scl, sda, busy, done});

		issue_cmd(slave_addr);
		wait_idle();
		issue_cmd(slave_addr ^ 7'h2a); // nobody answers here.
		wait_idle();

		repeat (5) issue_cmd(pick_dev());
		wait_idle();

		// two of these find the queue full.
		repeat (fifo_depth + 3) issue_cmd(pick_dev());
		wait_idle();
		check_value("cmd_overflow pulses", 2, ovf_seen);

		$display("closing report: %0d mismatches, %0d timeouts, %0d assertion failures",
			errors, timeouts, i_dut.i_chk.fails);
		if (errors == 0 && timeouts == 0 && i_dut.i_chk.fails == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

//--- all.f
source/i2c_pkg.sv
source/i2c_cmd_fifo.sv
source/i2c_bit_timer.sv
source/i2c_write_master.sv
source/i2c_write_top.sv
dv/i2c_slave_model.sv
dv/i2c_write_chk.sv
dv/i2c_write_tb.sv
